//--- Bender.yml
package:
  name: dual_issue_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/dualIssuePkg.sv
      - verilog/laneIf.sv
      - verilog/fetchUnit.sv
      - verilog/decodeLane.sv
      - verilog/regFile.sv
      - verilog/aluLane.sv
      - verilog/dualIssueCore.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/dualIssueTb.sv

//--- dv/dualIssueTb.sv
`include "dualIssue_cfg.svh"

module dualIssueTb;

    logic                  clock;
    logic                  reset;
    logic                  wbCyc;
    logic                  wbStb;
    logic                  wbWe;
    logic [`XLEN-1:0]      wbAdr;
    logic [`FETCH_W-1:0]   wbDatIn;
    logic                  wbAck;
    logic                  retireValidA;
    logic                  retireValidB;
    logic [`REG_IDX_W-1:0] retireRdA;
    logic [`REG_IDX_W-1:0] retireRdB;
    logic [`XLEN-1:0]      retireDataA;
    logic [`XLEN-1:0]      retireDataB;

    // expected retirements held as {rd, data}
    logic [`FETCH_W-1:0]          pairs [$];
    logic [`REG_IDX_W+`XLEN-1:0]  expA [$];
    logic [`REG_IDX_W+`XLEN-1:0]  expB [$];
    int errorCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;
    int waitLeft = 0;
    bit ackPending = 1'b0;

    dualIssueCore dut_i (
        .clock(clock), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbWe(wbWe),
        .wbDatIn(wbDatIn), .wbAck(wbAck),
        .retireValidA(retireValidA), .retireRdA(retireRdA), .retireDataA(retireDataA),
        .retireValidB(retireValidB), .retireRdB(retireRdB), .retireDataB(retireDataB)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic compareValue(input string what, input logic [`XLEN-1:0] got,
                                input logic [`XLEN-1:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic checkRetire(input string lane, input int left,
                               input logic [`REG_IDX_W+`XLEN-1:0] expected,
                               input logic [`REG_IDX_W-1:0] rd, input logic [`XLEN-1:0] data);
        if (left == 0) begin
            errorCount++;
            $display("lane %s retired x%0d although no retirement was expected", lane, rd);
        end else begin
            compareValue({"lane ", lane, " rd"}, rd, expected[`REG_IDX_W+`XLEN-1:`XLEN]);
            compareValue({"lane ", lane, " data"}, data, expected[`XLEN-1:0]);
        end
    endtask

    // P lines hold a pair, E lines one expected retirement
    task automatic loadProgram(output bit ok);
        int fd;
        int code;
        int rd;
        logic [63:0] tag;
        logic [63:0] laneTag;
        logic [8*128-1:0] rest;
        logic [`INST_W-1:0] instLo;
        logic [`INST_W-1:0] instHi;
        logic [`XLEN-1:0] value;
        fd = $fopen("dv/program_input.dat", "r");
        ok = (fd != 0);
        if (ok) begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "P") begin
                    code = $fscanf(fd, "%h %h", instLo, instHi);
                    ok = ok && (code == 2);
                    pairs.push_back({instHi, instLo});
                end else if (tag == "E") begin
                    code = $fscanf(fd, "%s %d %h", laneTag, rd, value);
                    ok = ok && (code == 3);
                    if (laneTag == "A") begin
                        expA.push_back({`REG_IDX_W'(rd), value});
                    end else begin
                        expB.push_back({`REG_IDX_W'(rd), value});
                    end
                end else begin
                    // comment line
                    code = $fgets(rest, fd);
                end
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // wishbone slave, 0 to 3 wait states
    // ----------------------------------------
    initial begin
        int seedValue;
        seedValue = $urandom(57743);
        forever begin
            @(posedge clock);
            #1;
            if (wbCyc && wbStb && !reset) begin
                if (!ackPending) begin
                    ackPending = 1'b1;
                    waitLeft = $urandom % 4;
                end
                if (waitLeft == 0) begin
                    wbAck = 1'b1;
                    wbDatIn = ((wbAdr >> 3) < pairs.size()) ? pairs[wbAdr >> 3]
                                                            : {`NOP_INST, `NOP_INST};
                    ackPending = 1'b0;
                end else begin
                    wbAck = 1'b0;
                    waitLeft--;
                end
            end else begin
                wbAck = 1'b0;
                ackPending = 1'b0;
            end
        end
    end

    // ----------------------------------------
    // retire checker, sampled mid-cycle
    // ----------------------------------------
    always @(negedge clock) begin
        if (reset && cycleCount > 0) begin
            compareValue("wbCyc during reset", wbCyc, '0);
            compareValue("retireValidA during reset", retireValidA, '0);
            compareValue("retireValidB during reset", retireValidB, '0);
        end else if (!reset) begin
            // read-only master
            compareValue("wbWe", wbWe, '0);
            if (retireValidA) begin
                checkRetire("A", expA.size(), (expA.size() > 0) ? expA[0] : '0,
                            retireRdA, retireDataA);
                if (expA.size() > 0) begin
                    expA.delete(0);
                end
            end
            if (retireValidB) begin
                checkRetire("B", expB.size(), (expB.size() > 0) ? expB[0] : '0,
                            retireRdB, retireDataB);
                if (expB.size() > 0) begin
                    expB.delete(0);
                end
            end
        end
    end

    initial begin
        bit fileOk;
        reset = 1'b1;
        wbAck = 1'b0;
        wbDatIn = {`NOP_INST, `NOP_INST};
        loadProgram(fileOk);
        // slowest pair takes five cycles
        cycleLimit = 5 * pairs.size() + 40;
        if (!fileOk) begin
            errorCount++;
            $display("could not open or parse dv/program_input.dat");
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        while (fileOk && (expA.size() + expB.size()) > 0 && cycleCount < cycleLimit) begin
            @(posedge clock);
        end
        if ((expA.size() + expB.size()) > 0) begin
            errorCount++;
            $display("timeout at cycle %0d, %0d lane A and %0d lane B retirements never came",
                     cycleCount, expA.size(), expB.size());
        end
        // trailing nop pairs must not retire
        repeat (8) @(posedge clock);
        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- dv/program_input.dat
# P <lane A inst hex> <lane B inst hex>, one pair per line, pc = 8 * pair index
# E <lane A|B> <rd decimal> <expected value hex>, in retire order per lane
P 00500093 FFD00113
E A 1 00000005
E B 2 FFFFFFFD
P 800001B7 7FF00213
E A 3 80000000
E B 4 000007FF
P 12345297 00001317
E A 5 12345010
E B 6 00001014
P 11100393 22200393
E A 7 00000111
E B 7 00000222
P 40100433 06308013
E A 8 FFFFFFFB
P 0041A4B3 0041B533
E A 9 00000001
E B 10 00000000
P 40115593 00409633
E A 11 FFFFFFFE
E B 12 80000000
P 00138693 80014713
E A 13 00000223
E B 14 000007FD
P 001067B3 00145833
E A 15 00000005
E B 16 07FFFFFF

//--- verilog.f
+incdir+verilog
verilog/dualIssuePkg.sv
verilog/laneIf.sv
verilog/fetchUnit.sv
verilog/decodeLane.sv
verilog/regFile.sv
verilog/aluLane.sv
verilog/dualIssueCore.sv
dv/dualIssueTb.sv

//--- verilog/aluLane.sv
`include "dualIssue_cfg.svh"

module aluLane (
    input  logic                  clock,
    input  logic                  reset,
    laneIf.execute                exec,
    output logic                  retireValid,
    output logic [`REG_IDX_W-1:0] retireRd,
    output logic [`XLEN-1:0]      retireData
);

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic             lessSigned;
    logic             lessUnsigned;
    logic [`XLEN-1:0] result;

    assign opA          = exec.operandA;
    assign opB          = exec.operandB;
    assign shamt        = opB[4:0];
    assign lessSigned   = $signed(opA) < $signed(opB);
    assign lessUnsigned = opA < opB;

    // ----------------------------------------
    // alu
    // ----------------------------------------
    always_comb begin
        case (exec.aluOp)
            dualIssuePkg::aluAdd:  result = opA + opB;
            dualIssuePkg::aluSub:  result = opA - opB;
            dualIssuePkg::aluSll:  result = opA << shamt;
            dualIssuePkg::aluSlt:  result = {{(`XLEN-1){1'b0}}, lessSigned};
            dualIssuePkg::aluSltu: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
            dualIssuePkg::aluXor:  result = opA ^ opB;
            dualIssuePkg::aluSrl:  result = opA >> shamt;
            // sign bit fills from the left
            dualIssuePkg::aluSra:  result = $signed(opA) >>> shamt;
            dualIssuePkg::aluOr:   result = opA | opB;
            dualIssuePkg::aluAnd:  result = opA & opB;
            default:               result = '0;
        endcase
    end

    // ----------------------------------------
    // execute/writeback register
    // ----------------------------------------
    // bubbles and x0 targets never retire
    always_ff @(posedge clock) begin
        if (reset) begin
            retireValid <= 1'b0;
        end else begin
            retireValid <= exec.valid && exec.writeEnable;
        end
    end

    always_ff @(posedge clock) begin
        retireRd   <= exec.rd;
        retireData <= result;
    end

endmodule

//--- verilog/decodeLane.sv
`include "dualIssue_cfg.svh"

module decodeLane #(
    parameter int laneOffset = 0
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`INST_W-1:0]    inst,
    input  logic [`XLEN-1:0]      pairPc,
    input  logic                  pairValid,
    output logic [`REG_IDX_W-1:0] rs1Addr,
    output logic [`REG_IDX_W-1:0] rs2Addr,
    input  logic [`XLEN-1:0]      rs1Data,
    input  logic [`XLEN-1:0]      rs2Data,
    laneIf.issue                  issue
);

    dualIssuePkg::opcodeT  opcode;
    dualIssuePkg::aluOpT   arithOp;
    dualIssuePkg::aluOpT   aluOp;
    logic [2:0]            funct3;
    logic                  altBit;
    logic                  isRegOp;
    logic                  isKept;
    logic [`REG_IDX_W-1:0] rd;
    logic [`XLEN-1:0]      immI;
    logic [`XLEN-1:0]      immU;
    logic [`XLEN-1:0]      lanePc;
    logic [`XLEN-1:0]      operandA;
    logic [`XLEN-1:0]      operandB;

    // ----------------------------------------
    // fields and immediates
    // ----------------------------------------
    assign opcode  = dualIssuePkg::opcodeT'(inst[6:0]);
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    // funct7 bit 5 selects sub and sra
    assign altBit  = inst[30];
    assign immI    = {{(`XLEN-12){inst[31]}}, inst[31:20]};
    assign immU    = {inst[31:12], 12'b0};
    assign lanePc  = pairPc + `XLEN'(laneOffset);
    assign isRegOp = (opcode == dualIssuePkg::opOp);

    // addi has no subtract form
    always_comb begin
        case (funct3)
            3'b000:  arithOp = (isRegOp && altBit) ? dualIssuePkg::aluSub : dualIssuePkg::aluAdd;
            3'b001:  arithOp = dualIssuePkg::aluSll;
            3'b010:  arithOp = dualIssuePkg::aluSlt;
            3'b011:  arithOp = dualIssuePkg::aluSltu;
            3'b100:  arithOp = dualIssuePkg::aluXor;
            3'b101:  arithOp = altBit ? dualIssuePkg::aluSra : dualIssuePkg::aluSrl;
            3'b110:  arithOp = dualIssuePkg::aluOr;
            default: arithOp = dualIssuePkg::aluAnd;
        endcase
    end

    // operand select per opcode
    always_comb begin
        aluOp    = dualIssuePkg::aluAdd;
        operandA = '0;
        operandB = '0;
        isKept   = 1'b1;
        case (opcode)
            dualIssuePkg::opOp: begin
                aluOp    = arithOp;
                operandA = rs1Data;
                operandB = rs2Data;
            end
            dualIssuePkg::opImm: begin
                aluOp    = arithOp;
                operandA = rs1Data;
                operandB = immI;
            end
            dualIssuePkg::opLui: begin
                operandB = immU;
            end
            dualIssuePkg::opAuipc: begin
                operandA = lanePc;
                operandB = immU;
            end
            default: begin
                isKept = 1'b0;
            end
        endcase
    end

    // ----------------------------------------
    // decode/execute register
    // ----------------------------------------
    always_ff @(posedge clock) begin
        if (reset) begin
            issue.valid       <= 1'b0;
            issue.writeEnable <= 1'b0;
        end else begin
            issue.valid       <= pairValid;
            issue.writeEnable <= pairValid && isKept && (rd != '0);
        end
    end

    always_ff @(posedge clock) begin
        issue.aluOp    <= aluOp;
        issue.operandA <= operandA;
        issue.operandB <= operandB;
        issue.rd       <= rd;
    end

endmodule

//--- verilog/dualIssueCore.sv
`include "dualIssue_cfg.svh"

module dualIssueCore (
    input  logic                  clock,
    input  logic                  reset,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic [`XLEN-1:0]      wbAdr,
    output logic                  wbWe,
    input  logic [`FETCH_W-1:0]   wbDatIn,
    input  logic                  wbAck,
    output logic                  retireValidA,
    output logic [`REG_IDX_W-1:0] retireRdA,
    output logic [`XLEN-1:0]      retireDataA,
    output logic                  retireValidB,
    output logic [`REG_IDX_W-1:0] retireRdB,
    output logic [`XLEN-1:0]      retireDataB
);

    logic [`INST_W-1:0]    instA;
    logic [`INST_W-1:0]    instB;
    logic [`XLEN-1:0]      pairPc;
    logic                  pairValid;
    logic [`REG_IDX_W-1:0] rs1AddrA;
    logic [`REG_IDX_W-1:0] rs2AddrA;
    logic [`REG_IDX_W-1:0] rs1AddrB;
    logic [`REG_IDX_W-1:0] rs2AddrB;
    logic [`XLEN-1:0]      rs1DataA;
    logic [`XLEN-1:0]      rs2DataA;
    logic [`XLEN-1:0]      rs1DataB;
    logic [`XLEN-1:0]      rs2DataB;

    laneIf laneA ();
    laneIf laneB ();

    // read-only master
    assign wbWe = 1'b0;

    // ----------------------------------------
    // fetch
    // ----------------------------------------
    fetchUnit fetch_i (
        .clock(clock), .reset(reset),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
        .wbDatIn(wbDatIn), .wbAck(wbAck),
        .instA(instA), .instB(instB),
        .pairPc(pairPc), .pairValid(pairValid)
    );

    // ----------------------------------------
    // decode, one per lane
    // ----------------------------------------
    decodeLane #(.laneOffset(0)) decodeA (
        .clock(clock), .reset(reset),
        .inst(instA), .pairPc(pairPc), .pairValid(pairValid),
        .rs1Addr(rs1AddrA), .rs2Addr(rs2AddrA),
        .rs1Data(rs1DataA), .rs2Data(rs2DataA),
        .issue(laneA.issue)
    );

    decodeLane #(.laneOffset(4)) decodeB (
        .clock(clock), .reset(reset),
        .inst(instB), .pairPc(pairPc), .pairValid(pairValid),
        .rs1Addr(rs1AddrB), .rs2Addr(rs2AddrB),
        .rs1Data(rs1DataB), .rs2Data(rs2DataB),
        .issue(laneB.issue)
    );

    regFile regFile_i (
        .clock(clock), .reset(reset),
        .rdAddrA1(rs1AddrA), .rdAddrA2(rs2AddrA),
        .rdAddrB1(rs1AddrB), .rdAddrB2(rs2AddrB),
        .rdDataA1(rs1DataA), .rdDataA2(rs2DataA),
        .rdDataB1(rs1DataB), .rdDataB2(rs2DataB),
        .wrEnA(retireValidA), .wrEnB(retireValidB),
        .wrAddrA(retireRdA), .wrAddrB(retireRdB),
        .wrDataA(retireDataA), .wrDataB(retireDataB)
    );

    // ----------------------------------------
    // execute, one per lane
    // ----------------------------------------
    aluLane aluA (
        .clock(clock), .reset(reset), .exec(laneA.execute),
        .retireValid(retireValidA), .retireRd(retireRdA), .retireData(retireDataA)
    );

    aluLane aluB (
        .clock(clock), .reset(reset), .exec(laneB.execute),
        .retireValid(retireValidB), .retireRd(retireRdB), .retireData(retireDataB)
    );

endmodule

//--- verilog/dualIssuePkg.sv
package dualIssuePkg;

    // ----------------------------------------
    // major opcodes kept by this core
    // ----------------------------------------
    typedef enum logic [6:0] {
        // register-register alu ops
        opOp    = 7'b0110011,
        // register-immediate alu ops
        opImm   = 7'b0010011,
        opLui   = 7'b0110111,
        opAuipc = 7'b0010111
    } opcodeT;

    // ----------------------------------------
    // alu operations
    // ----------------------------------------
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        // shifts use the low five bits of operand b
        aluSll  = 4'd2,
        // signed compare
        aluSlt  = 4'd3,
        // unsigned compare
        aluSltu = 4'd4,
        aluXor  = 4'd5,
        aluSrl  = 4'd6,
        // arithmetic right shift, sign fills
        aluSra  = 4'd7,
        aluOr   = 4'd8,
        aluAnd  = 4'd9
    } aluOpT;

endpackage

//--- verilog/dualIssue_cfg.svh
`ifndef DUAL_ISSUE_CFG_SVH
`define DUAL_ISSUE_CFG_SVH

// ----------------------------------------
// datapath and register file
// ----------------------------------------
`define XLEN      32
`define NUM_REGS  32
`define REG_IDX_W 5

// ----------------------------------------
// instruction fetch
// ----------------------------------------
`define INST_W    32
// two instructions per bus read
`define FETCH_W   64
// addi x0, x0, 0
`define NOP_INST  32'h0000_0013
`define RESET_PC  32'h0000_0000

`endif

//--- verilog/fetchUnit.sv
`include "dualIssue_cfg.svh"

module fetchUnit (
    input  logic                clock,
    input  logic                reset,
    output logic                wbCyc,
    output logic                wbStb,
    output logic [`XLEN-1:0]    wbAdr,
    input  logic [`FETCH_W-1:0] wbDatIn,
    input  logic                wbAck,
    output logic [`INST_W-1:0]  instA,
    output logic [`INST_W-1:0]  instB,
    output logic [`XLEN-1:0]    pairPc,
    output logic                pairValid
);

    typedef enum logic {
        fetchIdle,
        fetchBusy
    } fetchStateT;

    fetchStateT          state;
    logic [`XLEN-1:0]    pc;
    logic                ackSeen;
    logic [`FETCH_W-1:0] bufPair;
    logic [`XLEN-1:0]    bufPc;
    logic                bufValid;

    // ----------------------------------------
    // wishbone classic read master
    // ----------------------------------------
    assign wbCyc   = (state == fetchBusy);
    assign wbStb   = (state == fetchBusy);
    assign wbAdr   = pc;
    assign ackSeen = wbCyc && wbAck;

    // request drops for one cycle after every ack
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= fetchIdle;
            pc    <= `RESET_PC;
        end else if (ackSeen) begin
            state <= fetchIdle;
            pc    <= pc + `XLEN'd8;
        end else begin
            state <= fetchBusy;
        end
    end

    // pair is sampled on the ack edge
    always_ff @(posedge clock) begin
        if (reset) begin
            bufValid <= 1'b0;
        end else begin
            bufValid <= ackSeen;
        end
    end

    always_ff @(posedge clock) begin
        if (ackSeen) begin
            bufPair <= wbDatIn;
            bufPc   <= pc;
        end
    end

    // ----------------------------------------
    // fetch/decode register
    // ----------------------------------------
    // low word is lane a, high word lane b; bubbles carry a nop
    always_ff @(posedge clock) begin
        if (reset) begin
            instA     <= `NOP_INST;
            instB     <= `NOP_INST;
            pairValid <= 1'b0;
        end else begin
            instA     <= bufValid ? bufPair[`INST_W-1:0] : `NOP_INST;
            instB     <= bufValid ? bufPair[`FETCH_W-1:`INST_W] : `NOP_INST;
            pairValid <= bufValid;
        end
    end

    always_ff @(posedge clock) begin
        pairPc <= bufPc;
    end

endmodule

//--- verilog/laneIf.sv
`include "dualIssue_cfg.svh"

interface laneIf;

    // one decoded instruction, decode to execute
    logic                    valid;
    dualIssuePkg::aluOpT     aluOp;
    logic [`XLEN-1:0]        operandA;
    logic [`XLEN-1:0]        operandB;
    logic [`REG_IDX_W-1:0]   rd;
    logic                    writeEnable;

    modport issue (
        output valid,
        output aluOp,
        output operandA,
        output operandB,
        output rd,
        output writeEnable
    );

    modport execute (
        input valid,
        input aluOp,
        input operandA,
        input operandB,
        input rd,
        input writeEnable
    );

endinterface

//--- verilog/regFile.sv
`include "dualIssue_cfg.svh"

module regFile (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [`REG_IDX_W-1:0] rdAddrA1,
    input  logic [`REG_IDX_W-1:0] rdAddrA2,
    input  logic [`REG_IDX_W-1:0] rdAddrB1,
    input  logic [`REG_IDX_W-1:0] rdAddrB2,
    output logic [`XLEN-1:0]      rdDataA1,
    output logic [`XLEN-1:0]      rdDataA2,
    output logic [`XLEN-1:0]      rdDataB1,
    output logic [`XLEN-1:0]      rdDataB2,
    input  logic                  wrEnA,
    input  logic                  wrEnB,
    input  logic [`REG_IDX_W-1:0] wrAddrA,
    input  logic [`REG_IDX_W-1:0] wrAddrB,
    input  logic [`XLEN-1:0]      wrDataA,
    input  logic [`XLEN-1:0]      wrDataB
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    // x0 is hardwired to zero
    assign rdDataA1 = (rdAddrA1 == '0) ? '0 : regs[rdAddrA1];
    assign rdDataA2 = (rdAddrA2 == '0) ? '0 : regs[rdAddrA2];
    assign rdDataB1 = (rdAddrB1 == '0) ? '0 : regs[rdAddrB1];
    assign rdDataB2 = (rdAddrB2 == '0) ? '0 : regs[rdAddrB2];

    // lane b written last, so it wins on a shared rd
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrEnA && (wrAddrA != '0)) begin
                regs[wrAddrA] <= wrDataA;
            end
            if (wrEnB && (wrAddrB != '0)) begin
                regs[wrAddrB] <= wrDataB;
            end
        end
    end

endmodule
